/* hw/win7_pkg.sv */
`default_nettype none

package win7_pkg;

  // pixel format
  localparam int PIX_W = 8;
  typedef logic [PIX_W-1:0] pix_t;

  // window edge in pixels
  localparam int WIN = 7;

  // frame geometry
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 12;
  localparam int COL_W    = 4;
  localparam int ROW_W    = 4;

  // holds 0 to WIN, the number of real columns in the window
  localparam int FILL_W = $clog2(WIN + 1);

  // one row of the window summed
  localparam int ROWSUM_W = PIX_W + $clog2(WIN);

  // 49 * 255 = 12495 fits in 14 bits
  localparam int SUM_W = 14;

  // element r*WIN + c, row 0 oldest line, column 0 oldest column
  typedef pix_t [WIN*WIN-1:0] win_t;

endpackage

`default_nettype wire

/* hw/line_buffer.sv */
`default_nettype none

module line_buffer
  import win7_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             frame_start_i,
  input  wire             pixel_valid_i,
  input  wire pix_t       pixel_i,
  output logic            tap_valid_o,
  output pix_t [WIN-1:0]  tap_o,
  output logic            tap_row_first_o,
  output logic            tap_rows_ok_o
);

  // index 0 holds the oldest line, WIN-2 the line just above the current one
  pix_t line_mem [WIN-1][IMG_COLS];

  logic [COL_W-1:0] col_q;
  logic [ROW_W-1:0] row_q;
  logic [COL_W-1:0] cur_col;
  logic [ROW_W-1:0] cur_row;
  logic             col_last;

  // a frame start puts the pixel that comes with it at (0, 0)
  assign cur_col  = frame_start_i ? '0 : col_q;
  assign cur_row  = frame_start_i ? '0 : row_q;
  assign col_last = (cur_col == COL_W'(IMG_COLS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (pixel_valid_i) begin
      if (col_last) begin
        col_q <= '0;
        // row stays on the last line until the next frame start
        if (cur_row != ROW_W'(IMG_ROWS - 1)) begin
          row_q <= cur_row + 1'b1;
        end else begin
          row_q <= cur_row;
        end
      end else begin
        col_q <= cur_col + 1'b1;
        row_q <= cur_row;
      end
    end
  end

  // each line moves up one slot at the current column
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int k = 0; k < WIN - 2; k++) begin
        line_mem[k][cur_col] <= line_mem[k+1][cur_col];
      end
      line_mem[WIN-2][cur_col] <= pixel_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tap_valid_o     <= 1'b0;
      tap_o           <= '0;
      tap_row_first_o <= 1'b0;
      tap_rows_ok_o   <= 1'b0;
    end else begin
      tap_valid_o <= pixel_valid_i;
      if (pixel_valid_i) begin
        for (int k = 0; k < WIN - 1; k++) begin
          tap_o[k] <= line_mem[k][cur_col];
        end
        tap_o[WIN-1]    <= pixel_i;
        tap_row_first_o <= (cur_col == '0);
        // six lines stored above means a full column of seven
        tap_rows_ok_o   <= (cur_row >= ROW_W'(WIN - 1));
      end
    end
  end

  a_start_with_pixel: assert property (
    @(posedge clk) disable iff (!rst_n)
    frame_start_i |-> pixel_valid_i
  ) else $error("frame_start_i high without pixel_valid_i");

endmodule

`default_nettype wire

/* hw/window_datapath.sv */
`default_nettype none

module window_datapath
  import win7_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             tap_valid_i,
  input  wire pix_t [WIN-1:0] tap_i,
  input  wire             tap_row_first_i,
  input  wire             tap_rows_ok_i,
  output logic            win_valid_o,
  output win_t            win_o
);

  logic [FILL_W-1:0] fill_q;
  logic [FILL_W-1:0] fill_nxt;
  logic              win_full;

  // count of real columns after the shift on this tap
  always_comb begin
    if (tap_row_first_i) begin
      fill_nxt = FILL_W'(1);
    end else if (fill_q == FILL_W'(WIN)) begin
      fill_nxt = fill_q;
    end else begin
      fill_nxt = fill_q + 1'b1;
    end
  end

  assign win_full = (fill_nxt >= FILL_W'(WIN));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_q <= '0;
    end else if (tap_valid_i) begin
      fill_q <= fill_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_valid_o <= 1'b0;
    end else begin
      win_valid_o <= tap_valid_i && tap_rows_ok_i && win_full;
    end
  end

  // one delay chain per window row, new column enters on the right
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_o <= '0;
    end else if (tap_valid_i) begin
      for (int r = 0; r < WIN; r++) begin
        for (int c = 0; c < WIN - 1; c++) begin
          win_o[r*WIN + c] <= win_o[r*WIN + c + 1];
        end
        win_o[r*WIN + WIN - 1] <= tap_i[r];
      end
    end
  end

  a_valid_after_tap: assert property (
    @(posedge clk) disable iff (!rst_n)
    win_valid_o |-> $past(tap_valid_i)
  ) else $error("win_valid_o without a tap in the previous cycle");

  a_fill_bounded: assert property (
    @(posedge clk) disable iff (!rst_n)
    fill_q <= FILL_W'(WIN)
  ) else $error("fill counter above window width");

endmodule

`default_nettype wire

/* hw/box_sum.sv */
`default_nettype none

module box_sum
  import win7_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              win_valid_i,
  input  wire win_t        win_i,
  output logic             sum_valid_o,
  output logic [SUM_W-1:0] sum_o,
  output pix_t             max_o
);

  logic [ROWSUM_W-1:0] row_sum_d [WIN];
  pix_t                row_max_d [WIN];
  logic [ROWSUM_W-1:0] row_sum_q [WIN];
  pix_t                row_max_q [WIN];
  logic                s1_valid_q;
  logic [SUM_W-1:0]    sum_d;
  pix_t                max_d;

  // stage one, per row reduction
  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      row_sum_d[r] = '0;
      row_max_d[r] = '0;
      for (int c = 0; c < WIN; c++) begin
        row_sum_d[r] = row_sum_d[r] + ROWSUM_W'(win_i[r*WIN + c]);
        if (win_i[r*WIN + c] > row_max_d[r]) begin
          row_max_d[r] = win_i[r*WIN + c];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      for (int r = 0; r < WIN; r++) begin
        row_sum_q[r] <= '0;
        row_max_q[r] <= '0;
      end
    end else begin
      s1_valid_q <= win_valid_i;
      for (int r = 0; r < WIN; r++) begin
        row_sum_q[r] <= row_sum_d[r];
        row_max_q[r] <= row_max_d[r];
      end
    end
  end

  // stage two, across rows
  always_comb begin
    sum_d = '0;
    max_d = '0;
    for (int r = 0; r < WIN; r++) begin
      sum_d = sum_d + SUM_W'(row_sum_q[r]);
      if (row_max_q[r] > max_d) begin
        max_d = row_max_q[r];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid_o <= 1'b0;
      sum_o       <= '0;
      max_o       <= '0;
    end else begin
      sum_valid_o <= s1_valid_q;
      sum_o       <= sum_d;
      max_o       <= max_d;
    end
  end

  a_sum_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_o <= SUM_W'(WIN * WIN * ((1 << PIX_W) - 1))
  ) else $error("window sum above 49 full-scale pixels");

endmodule

`default_nettype wire

/* hw/window_filter_top.sv */
`default_nettype none

module window_filter_top
  import win7_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              frame_start_i,
  input  wire              pixel_valid_i,
  input  wire pix_t        pixel_i,
  output wire              sum_valid_o,
  output wire [SUM_W-1:0]  sum_o,
  output wire pix_t        max_o
);

  // line buffer to window
  logic           tap_valid;
  pix_t [WIN-1:0] tap;
  logic           tap_row_first;
  logic           tap_rows_ok;

  // window to adder tree
  logic           win_valid;
  win_t           win;

  line_buffer u_line_buffer (
    .clk             (clk),
    .rst_n           (rst_n),
    .frame_start_i   (frame_start_i),
    .pixel_valid_i   (pixel_valid_i),
    .pixel_i         (pixel_i),
    .tap_valid_o     (tap_valid),
    .tap_o           (tap),
    .tap_row_first_o (tap_row_first),
    .tap_rows_ok_o   (tap_rows_ok)
  );

  window_datapath u_window (
    .clk             (clk),
    .rst_n           (rst_n),
    .tap_valid_i     (tap_valid),
    .tap_i           (tap),
    .tap_row_first_i (tap_row_first),
    .tap_rows_ok_i   (tap_rows_ok),
    .win_valid_o     (win_valid),
    .win_o           (win)
  );

  box_sum u_box_sum (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_valid_i (win_valid),
    .win_i       (win),
    .sum_valid_o (sum_valid_o),
    .sum_o       (sum_o),
    .max_o       (max_o)
  );

endmodule

`default_nettype wire

/* verif/tb_window_filter.sv */
`default_nettype none

module tb_window_filter
  import win7_pkg::*;
();

  localparam int PERIOD       = 4;
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY      = 4;
  localparam int NUM_FRAMES   = 6;
  localparam int DRAIN_LIMIT  = 16;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * IMG_COLS * IMG_ROWS * 4 + 200;

  logic             clk;
  logic             rst_n;
  logic             frame_start_i;
  logic             pixel_valid_i;
  pix_t             pixel_i;
  logic             sum_valid_o;
  logic [SUM_W-1:0] sum_o;
  pix_t             max_o;

  // marks the pixel that completes the first window of a timed frame
  logic             mark_q;

  pix_t             frame_pix [IMG_ROWS][IMG_COLS];
  logic [SUM_W-1:0] exp_sum [$];
  pix_t             exp_max [$];

  logic [31:0] rand_state = 32'hd26d;
  int errors = 0;
  int checks = 0;
  int cycle_cnt = 0;
  int mark_cycle = 0;
  bit mark_pending = 0;
  int latency_checks = 0;

  window_filter_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start_i (frame_start_i),
    .pixel_valid_i (pixel_valid_i),
    .pixel_i       (pixel_i),
    .sum_valid_o   (sum_valid_o),
    .sum_o         (sum_o),
    .max_o         (max_o)
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // results and latency, sampled on the rising edge
  always @(posedge clk) begin
    logic [SUM_W-1:0] s;
    pix_t             m;
    cycle_cnt++;
    if (pixel_valid_i && mark_q) begin
      mark_cycle   = cycle_cnt;
      mark_pending = 1'b1;
    end
    if (sum_valid_o) begin
      if (mark_pending) begin
        // seen LATENCY edges after the accepting edge
        check("sum_valid_o latency", 32'(cycle_cnt - mark_cycle), 32'(LATENCY));
        mark_pending = 1'b0;
        latency_checks++;
      end
      if (exp_sum.size() == 0) begin
        $display("unexpected result with sum 0x%0h and max 0x%0h", sum_o, max_o);
        errors++;
      end else begin
        s = exp_sum.pop_front();
        m = exp_max.pop_front();
        check("sum_o", 32'(sum_o), 32'(s));
        check("max_o", 32'(max_o), 32'(m));
      end
    end
  end

  // reference box filter over every interior 7x7 window, raster order
  task automatic compute_expected();
    int   s;
    pix_t m;
    for (int br = WIN - 1; br < IMG_ROWS; br++) begin
      for (int bc = WIN - 1; bc < IMG_COLS; bc++) begin
        s = 0;
        m = '0;
        for (int r = br - WIN + 1; r <= br; r++) begin
          for (int c = bc - WIN + 1; c <= bc; c++) begin
            s += int'(frame_pix[r][c]);
            if (frame_pix[r][c] > m) begin
              m = frame_pix[r][c];
            end
          end
        end
        exp_sum.push_back(SUM_W'(s));
        exp_max.push_back(m);
      end
    end
  endtask

  task automatic fill_ramp();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        frame_pix[r][c] = pix_t'((r * 16 + c) % 256);
      end
    end
  endtask

  task automatic fill_random();
    logic [31:0] rnd;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        rnd = next_rand();
        frame_pix[r][c] = rnd[23:16];
      end
    end
  endtask

  task automatic fill_const(input pix_t v);
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        frame_pix[r][c] = v;
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      pixel_valid_i <= 1'b0;
      frame_start_i <= 1'b0;
      mark_q        <= 1'b0;
    end
  endtask

  // leaves the last pixel on the bus so a new frame can follow at once
  task automatic drive_frame(input int n_rows, input int max_gap, input bit timed);
    int gap;
    for (int r = 0; r < n_rows; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        gap = 0;
        if (max_gap > 0) begin
          gap = int'(next_rand() >> 16) % (max_gap + 1);
        end
        if (gap > 0) begin
          idle(gap);
        end
        @(posedge clk);
        pixel_valid_i <= 1'b1;
        pixel_i       <= frame_pix[r][c];
        frame_start_i <= (r == 0 && c == 0);
        mark_q        <= timed && (r == WIN - 1) && (c == WIN - 1);
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_sum.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_sum.size() != 0) begin
      $display("%0d expected results never arrived", exp_sum.size());
      errors += exp_sum.size();
      exp_sum.delete();
      exp_max.delete();
    end
    // room for any stray result to show up
    repeat (2 * LATENCY) @(posedge clk);
  endtask

  task automatic test_reset_state();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      check("sum_valid_o", 32'(sum_valid_o), 32'h0);
    end
    rst_n <= 1'b1;
    repeat (10) begin
      @(posedge clk);
      check("sum_valid_o", 32'(sum_valid_o), 32'h0);
    end
  endtask

  task automatic test_ramp();
    int seen;
    seen = latency_checks;
    fill_ramp();
    compute_expected();
    drive_frame(IMG_ROWS, 0, 1'b1);
    idle(1);
    wait_drain();
    if (latency_checks != seen + 1) begin
      $display("ramp frame gave no first result to time");
      errors++;
    end
  endtask

  task automatic test_gapped();
    fill_random();
    compute_expected();
    drive_frame(IMG_ROWS, 3, 1'b0);
    idle(1);
    wait_drain();
  endtask

  task automatic test_saturation();
    fill_const(8'hff);
    compute_expected();
    drive_frame(IMG_ROWS, 0, 1'b0);
    idle(1);
    wait_drain();
    fill_const(8'h00);
    compute_expected();
    drive_frame(IMG_ROWS, 0, 1'b0);
    idle(1);
    wait_drain();
  endtask

  task automatic test_restart();
    fill_random();
    drive_frame(5, 0, 1'b0);
    fill_random();
    compute_expected();
    drive_frame(IMG_ROWS, 0, 1'b0);
    idle(1);
    wait_drain();
  endtask

  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("timeout after %0d cycles, tests did not complete", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst_n         = 1'b0;
    frame_start_i = 1'b0;
    pixel_valid_i = 1'b0;
    pixel_i       = '0;
    mark_q        = 1'b0;
    test_reset_state();
    test_ramp();
    test_gapped();
    test_saturation();
    test_restart();
    $display("errors %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/win7_pkg.sv
hw/line_buffer.sv
hw/window_datapath.sv
hw/box_sum.sv
hw/window_filter_top.sv
verif/tb_window_filter.sv

/* run.sh */
#!/bin/sh
# build and run the window filter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_window_filter -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  && grep -qx '=== PASS ===' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
